//--- build.f
+incdir+verilog
verilog/simmem_pkg.sv
verilog/axil_slave_port.sv
verilog/word_ram.sv
verilog/host_ctrl_regs.sv
verilog/simmem_top.sv
bench/tb_clock_gen.sv
bench/simmem_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the simmem testbench with verilator, run it and scan the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module simmem_tb \
  -Mdir obj_dir -o simmem_sim

./obj_dir/simmem_sim | tee sim.log

if grep -q "test failed" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
echo "simulation clean"

//--- bench/simmem_tb.sv
`timescale 1ns/1ns
`include "simmem_defines.svh"

module simmem_tb;

  localparam int HS_LIMIT    = 20;                  // cycles allowed for one handshake
  localparam int WATCHDOG_NS = 6 * 40 * 30 * 20;    // tests x transfers x cycles x period

  logic clk;
  logic arst_n;
  simmem_pkg::addr_t awaddr;
  simmem_pkg::addr_t araddr;
  simmem_pkg::data_t wdata;
  simmem_pkg::data_t rdata;
  simmem_pkg::data_t exit_value;
  simmem_pkg::strb_t wstrb;
  simmem_pkg::resp_t bresp;
  simmem_pkg::resp_t rresp;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic print_valid, tests_passed, tests_failed, exit_valid;
  logic [7:0] print_data;

  integer seed = 32'h6107_e546;
  simmem_pkg::data_t    model [1024];               // expected ram contents
  simmem_pkg::ram_idx_t idx_q [$];                  // ram indices written so far
  int err_cnt = 0;
  int ok_cnt  = 0;
  int bad_cnt = 0;
  int n_print = 0;                                  // pulse counters
  int n_pass  = 0;
  int n_fail  = 0;
  int n_exit  = 0;
  simmem_pkg::resp_t last_resp;                     // last b or r response
  simmem_pkg::data_t last_rdata;
  logic cap_pv, cap_tp, cap_tf, cap_ev;             // host pulses in the first bvalid cycle
  logic [7:0] cap_pd;
  simmem_pkg::data_t cap_evv;

  tb_clock_gen i_clk (.clk_o(clk), .arst_n_o(arst_n));

  simmem_top i_dut (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .s_awaddr_i     (awaddr),
    .s_awvalid_i    (awvalid),
    .s_awready_o    (awready),
    .s_wdata_i      (wdata),
    .s_wstrb_i      (wstrb),
    .s_wvalid_i     (wvalid),
    .s_wready_o     (wready),
    .s_bresp_o      (bresp),
    .s_bvalid_o     (bvalid),
    .s_bready_i     (bready),
    .s_araddr_i     (araddr),
    .s_arvalid_i    (arvalid),
    .s_arready_o    (arready),
    .s_rdata_o      (rdata),
    .s_rresp_o      (rresp),
    .s_rvalid_o     (rvalid),
    .s_rready_i     (rready),
    .print_valid_o  (print_valid),
    .print_data_o   (print_data),
    .tests_passed_o (tests_passed),
    .tests_failed_o (tests_failed),
    .exit_valid_o   (exit_valid),
    .exit_value_o   (exit_value)
  );

  always @(negedge clk) begin                       // pulses are one cycle wide
    if (print_valid) n_print++;
    if (tests_passed) n_pass++;
    if (tests_failed) n_fail++;
    if (exit_valid) n_exit++;
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------
  task automatic next_cycle();
    @(posedge clk);
    #2;                                             // drive phase
  endtask

  task automatic flag_mismatch(input string msg);
    $display("MISMATCH at %0t ns: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic note_failure(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    err_cnt++;
  endtask

  function automatic simmem_pkg::addr_t region_addr(input logic [1:0] region,
                                                    input logic [11:0] ofs);
    simmem_pkg::addr_t a;
    a = '0;
    a[`SIMMEM_REGION_LSB +: 2] = region;            // bits 29:28 pick the target
    a[11:0] = ofs;
    return a;
  endfunction

  function automatic simmem_pkg::data_t merge_lanes(input simmem_pkg::data_t old_w,
                                                    input simmem_pkg::data_t new_w,
                                                    input simmem_pkg::strb_t strb);
    simmem_pkg::data_t m;
    m = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) m[8*b +: 8] = new_w[8*b +: 8];   // strobed lane takes new byte
    end
    return m;
  endfunction

  task automatic check_quiet(input string when);
    if ({awready, wready, arready, bvalid, rvalid, print_valid,
         tests_passed, tests_failed, exit_valid} !== 9'b0) begin
      flag_mismatch({"handshake or pulse output not low ", when});
    end
  endtask

  // --------------------------------------------------------------------------
  // bus transfers with hold cycles of bready/rready low after valid
  // --------------------------------------------------------------------------
  task automatic axi_write(input simmem_pkg::addr_t addr, input simmem_pkg::data_t data,
                           input simmem_pkg::strb_t strb, input int hold);
    int waited;
    waited  = 0;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge clk);
    while (!(awready && wready) && waited < HS_LIMIT) begin
      next_cycle();
      @(negedge clk);
      waited++;
    end
    if ((awready && wready) !== 1'b1) note_failure("write address and data never accepted");
    next_cycle();                                   // aw/w handshake edge
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = (hold == 0);
    for (int c = 0; c <= hold; c++) begin
      arvalid = (c < hold);                         // read offered while b is stalled
      araddr  = region_addr(2'd3, 12'h0);
      @(negedge clk);
      if (bvalid !== 1'b1) note_failure("write response missing");
      if (c == 0) begin
        last_resp = bresp;
        cap_pv    = print_valid;
        cap_pd    = print_data;
        cap_tp    = tests_passed;
        cap_tf    = tests_failed;
        cap_ev    = exit_valid;
        cap_evv   = exit_value;
      end else if (bresp !== last_resp) begin
        flag_mismatch($sformatf("bresp moved to %0d while stalled", bresp));
      end
      if (c < hold && (awready | wready | arready) !== 1'b0) begin
        flag_mismatch("ready high while b stalled");
      end
      next_cycle();
      arvalid = 1'b0;
      if (c + 1 == hold) bready = 1'b1;
    end
    bready = 1'b0;
  endtask

  task automatic axi_read(input simmem_pkg::addr_t addr, input int hold);
    int waited;
    waited  = 0;
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready && waited < HS_LIMIT) begin
      next_cycle();
      @(negedge clk);
      waited++;
    end
    if (arready !== 1'b1) note_failure("read address never accepted");
    next_cycle();                                   // ar handshake edge
    arvalid = 1'b0;
    rready  = (hold == 0);
    for (int c = 0; c <= hold; c++) begin
      awvalid = (c < hold);                         // write offered while r is stalled
      wvalid  = (c < hold);
      awaddr  = region_addr(2'd3, 12'h0);
      wstrb   = '0;
      @(negedge clk);
      if (rvalid !== 1'b1) note_failure("read response missing");
      if (c == 0) begin
        last_rdata = rdata;
        last_resp  = rresp;
      end else if (rdata !== last_rdata || rresp !== last_resp) begin
        flag_mismatch($sformatf("r channel moved to %h/%0d while stalled", rdata, rresp));
      end
      if (c < hold && (awready | wready | arready) !== 1'b0) begin
        flag_mismatch("ready high while r stalled");
      end
      next_cycle();
      awvalid = 1'b0;
      wvalid  = 1'b0;
      if (c + 1 == hold) rready = 1'b1;
    end
    rready = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------
  task automatic reset_outputs_low();
    do begin
      @(negedge clk);
      check_quiet("around reset");
    end while (!arst_n);                            // one more look after release
    next_cycle();
  endtask

  task automatic ram_strobe_rw();
    simmem_pkg::data_t    r;
    simmem_pkg::data_t    d;
    simmem_pkg::ram_idx_t idx;
    for (int i = 0; i < 32; i++) begin
      r   = $random(seed);
      idx = r[9:0];
      d   = $random(seed);
      axi_write(region_addr(`SIMMEM_REGION_RAM, {idx, 2'b00}), d, 4'hf, 0);
      if (last_resp !== `SIMMEM_RESP_OKAY) begin
        flag_mismatch($sformatf("ram bresp %0d", last_resp));
      end
      model[idx] = d;
      idx_q.push_back(idx);
    end
    for (int i = 0; i < 8; i++) begin               // partial rewrites
      idx = idx_q[i*4];
      r   = $random(seed);
      d   = $random(seed);
      axi_write(region_addr(`SIMMEM_REGION_RAM, {idx, 2'b00}), d, r[3:0], 0);
      model[idx] = merge_lanes(model[idx], d, r[3:0]);
    end
    foreach (idx_q[i]) begin
      axi_read(region_addr(`SIMMEM_REGION_RAM, {idx_q[i], 2'b00}), 0);
      if (last_rdata !== model[idx_q[i]] || last_resp !== `SIMMEM_RESP_OKAY) begin
        flag_mismatch($sformatf("ram[%0d] read %h/%0d, expected %h/0", idx_q[i],
                                last_rdata, last_resp, model[idx_q[i]]));
      end
    end
  endtask

  task automatic print_port_pulse();
    int p0;
    p0 = n_print;
    axi_write(region_addr(`SIMMEM_REGION_PRINT, 12'h0), 32'h1234_5641, 4'hf, 0);
    if (cap_pv !== 1'b1 || cap_pd !== 8'h41) begin
      flag_mismatch($sformatf("print %b/%h, expected 1/41", cap_pv, cap_pd));
    end
    if (n_print != p0 + 1) begin
      flag_mismatch($sformatf("%0d print pulses, expected 1", n_print - p0));
    end
    axi_write(region_addr(`SIMMEM_REGION_PRINT, 12'h0), 32'h0000_0042, 4'h0, 0);
    if (n_print != p0 + 1) flag_mismatch("print pulse from a write without strobes");
    axi_read(region_addr(`SIMMEM_REGION_PRINT, 12'h0), 0);
    if (last_rdata !== 0 || last_resp !== `SIMMEM_RESP_OKAY) begin
      flag_mismatch($sformatf("print read %h/%0d, expected 0/0", last_rdata, last_resp));
    end
  endtask

  task automatic exit_and_status();
    int s0;
    int f0;
    int e0;
    axi_write(region_addr(`SIMMEM_REGION_CTRL, `SIMMEM_CTRL_STATUS_OFS), 32'd123456789, 4'hf, 0);
    if (cap_tp !== 1'b1 || cap_tf !== 1'b0) begin
      flag_mismatch($sformatf("pass magic gave %b/%b", cap_tp, cap_tf));
    end
    axi_write(region_addr(`SIMMEM_REGION_CTRL, `SIMMEM_CTRL_STATUS_OFS), 32'd1, 4'hf, 0);
    if (cap_tp !== 1'b0 || cap_tf !== 1'b1) begin
      flag_mismatch($sformatf("fail magic gave %b/%b", cap_tp, cap_tf));
    end
    s0 = n_pass;
    f0 = n_fail;
    e0 = n_exit;
    axi_write(region_addr(`SIMMEM_REGION_CTRL, `SIMMEM_CTRL_STATUS_OFS), 32'd42, 4'hf, 0);
    if (n_pass != s0 || n_fail != f0 || n_exit != e0) flag_mismatch("status 42 raised a pulse");
    axi_write(region_addr(`SIMMEM_REGION_CTRL, `SIMMEM_CTRL_EXIT_OFS), 32'hcafe_0007, 4'hf, 0);
    if (cap_ev !== 1'b1 || cap_evv !== 32'hcafe_0007) begin
      flag_mismatch($sformatf("exit %b/%h", cap_ev, cap_evv));
    end
    axi_write(region_addr(`SIMMEM_REGION_CTRL, `SIMMEM_CTRL_EXIT0_OFS), 32'h55, 4'hf, 0);
    if (cap_ev !== 1'b1 || cap_evv !== 0) begin
      flag_mismatch($sformatf("exit0 %b/%h", cap_ev, cap_evv));
    end
  endtask

  task automatic unmapped_decerr();
    simmem_pkg::ram_idx_t idx;
    idx = idx_q[0];                                 // same low bits as a ram word
    axi_write(region_addr(2'd3, {idx, 2'b00}), 32'hffff_ffff, 4'hf, 0);
    if (last_resp !== `SIMMEM_RESP_DECERR) begin
      flag_mismatch($sformatf("unmapped bresp %0d", last_resp));
    end
    axi_read(region_addr(2'd3, {idx, 2'b00}), 0);
    if (last_rdata !== 0 || last_resp !== `SIMMEM_RESP_DECERR) begin
      flag_mismatch($sformatf("unmapped read %h/%0d, expected 0/3", last_rdata, last_resp));
    end
    axi_read(region_addr(`SIMMEM_REGION_RAM, {idx, 2'b00}), 0);
    if (last_rdata !== model[idx]) begin
      flag_mismatch($sformatf("ram[%0d] changed to %h", idx, last_rdata));
    end
  endtask

  task automatic stalled_responses();
    simmem_pkg::ram_idx_t idx;
    simmem_pkg::data_t    d;
    idx = idx_q[1];
    d   = $random(seed);
    axi_write(region_addr(`SIMMEM_REGION_RAM, {idx, 2'b00}), d, 4'hf, 5);
    model[idx] = d;
    axi_read(region_addr(`SIMMEM_REGION_RAM, {idx, 2'b00}), 5);
    if (last_rdata !== model[idx]) begin
      flag_mismatch($sformatf("stalled read %h, expected %h", last_rdata, model[idx]));
    end
    axi_read(region_addr(2'd3, 12'h0), 5);
    if (last_rdata !== 0 || last_resp !== `SIMMEM_RESP_DECERR) begin
      flag_mismatch("stalled decerr read");
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      ok_cnt++;
      $display("%s: ok", name);
    end else begin
      bad_cnt++;
      $display("%s: %0d errors", name, err_cnt - errs_before);
    end
  endtask

  // --------------------------------------------------------------------------
  // main sequence and watchdog
  // --------------------------------------------------------------------------
  initial begin
    int e;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    e = err_cnt;
    reset_outputs_low();
    report_test("reset state", e);
    e = err_cnt;
    ram_strobe_rw();
    report_test("ram strobes", e);
    e = err_cnt;
    print_port_pulse();
    report_test("print port", e);
    e = err_cnt;
    exit_and_status();
    report_test("exit and status", e);
    e = err_cnt;
    unmapped_decerr();
    report_test("unmapped region", e);
    e = err_cnt;
    stalled_responses();
    report_test("back-pressure", e);
    $display("summary: %0d ok, %0d with errors, %0d errors in all", ok_cnt, bad_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: run still going after %0d ns", WATCHDOG_NS);
    $display("test failed");
    $finish;
  end

endmodule

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk_o,                         // 20 ns period
  output logic arst_n_o                       // low for the first 3 rising edges
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // release in the drive phase, 2 ns after the third edge
  initial begin
    arst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    #2;
    arst_n_o = 1'b1;
  end

endmodule

//--- verilog/simmem_top.sv
`timescale 1ns/1ns
`include "simmem_defines.svh"

module simmem_top (
  input  logic              clk_i,
  input  logic              arst_n_i,
  // axi4-lite slave
  input  simmem_pkg::addr_t s_awaddr_i,
  input  logic              s_awvalid_i,
  output logic              s_awready_o,
  input  simmem_pkg::data_t s_wdata_i,
  input  simmem_pkg::strb_t s_wstrb_i,
  input  logic              s_wvalid_i,
  output logic              s_wready_o,
  output simmem_pkg::resp_t s_bresp_o,
  output logic              s_bvalid_o,
  input  logic              s_bready_i,
  input  simmem_pkg::addr_t s_araddr_i,
  input  logic              s_arvalid_i,
  output logic              s_arready_o,
  output simmem_pkg::data_t s_rdata_o,
  output simmem_pkg::resp_t s_rresp_o,
  output logic              s_rvalid_o,
  input  logic              s_rready_i,
  // host side
  output logic              print_valid_o,
  output logic [7:0]        print_data_o,
  output logic              tests_passed_o,
  output logic              tests_failed_o,
  output logic              exit_valid_o,
  output simmem_pkg::data_t exit_value_o
);

  // port to ram
  logic                 ram_en;
  logic                 ram_we;
  simmem_pkg::ram_idx_t ram_idx;
  simmem_pkg::data_t    ram_rdata;
  // port to ctrl, wdata/wstrb shared by both targets
  logic                 ctrl_wr;
  logic                 ctrl_print;
  logic [11:0]          ctrl_ofs;
  simmem_pkg::data_t    acc_wdata;
  simmem_pkg::strb_t    acc_wstrb;

  // ---------------------------------------------------------------------------
  // bus port with decoder
  // ---------------------------------------------------------------------------
  axil_slave_port i_port (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .s_awaddr_i   (s_awaddr_i),
    .s_awvalid_i  (s_awvalid_i),
    .s_awready_o  (s_awready_o),
    .s_wdata_i    (s_wdata_i),
    .s_wstrb_i    (s_wstrb_i),
    .s_wvalid_i   (s_wvalid_i),
    .s_wready_o   (s_wready_o),
    .s_bresp_o    (s_bresp_o),
    .s_bvalid_o   (s_bvalid_o),
    .s_bready_i   (s_bready_i),
    .s_araddr_i   (s_araddr_i),
    .s_arvalid_i  (s_arvalid_i),
    .s_arready_o  (s_arready_o),
    .s_rdata_o    (s_rdata_o),
    .s_rresp_o    (s_rresp_o),
    .s_rvalid_o   (s_rvalid_o),
    .s_rready_i   (s_rready_i),
    .ram_en_o     (ram_en),
    .ram_we_o     (ram_we),
    .ram_idx_o    (ram_idx),
    .ram_rdata_i  (ram_rdata),
    .ctrl_wr_o    (ctrl_wr),
    .ctrl_print_o (ctrl_print),
    .ctrl_ofs_o   (ctrl_ofs),
    .wdata_o      (acc_wdata),
    .wstrb_o      (acc_wstrb)
  );

  // ---------------------------------------------------------------------------
  // targets
  // ---------------------------------------------------------------------------
  word_ram i_ram (
    .clk_i   (clk_i),
    .en_i    (ram_en),
    .we_i    (ram_we),
    .idx_i   (ram_idx),
    .wdata_i (acc_wdata),
    .wstrb_i (acc_wstrb),
    .rdata_o (ram_rdata)
  );

  host_ctrl_regs i_ctrl (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .wr_i           (ctrl_wr),
    .print_i        (ctrl_print),
    .ofs_i          (ctrl_ofs),
    .wdata_i        (acc_wdata),
    .wstrb_i        (acc_wstrb),
    .print_valid_o  (print_valid_o),
    .print_data_o   (print_data_o),
    .tests_passed_o (tests_passed_o),
    .tests_failed_o (tests_failed_o),
    .exit_valid_o   (exit_valid_o),
    .exit_value_o   (exit_value_o)
  );

endmodule

//--- verilog/host_ctrl_regs.sv
`timescale 1ns/1ns
`include "simmem_defines.svh"

module host_ctrl_regs (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              wr_i,            // write strobe from the port
  input  logic              print_i,         // write targets the print region
  input  logic [11:0]       ofs_i,           // offset inside the ctrl region
  input  simmem_pkg::data_t wdata_i,
  input  simmem_pkg::strb_t wstrb_i,
  output logic              print_valid_o,
  output logic [7:0]        print_data_o,
  output logic              tests_passed_o,
  output logic              tests_failed_o,
  output logic              exit_valid_o,
  output simmem_pkg::data_t exit_value_o
);

  logic wr_act;                              // write with at least one lane

  assign wr_act = wr_i && (|wstrb_i);

  // ---------------------------------------------------------------------------
  // one-cycle pulses, values fall back to zero between them
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      print_valid_o  <= 1'b0;
      print_data_o   <= '0;
      tests_passed_o <= 1'b0;
      tests_failed_o <= 1'b0;
      exit_valid_o   <= 1'b0;
      exit_value_o   <= '0;
    end else begin
      print_valid_o  <= 1'b0;                // defaults end last pulse
      print_data_o   <= '0;
      tests_passed_o <= 1'b0;
      tests_failed_o <= 1'b0;
      exit_valid_o   <= 1'b0;
      exit_value_o   <= '0;
      if (wr_act && print_i) begin
        print_valid_o <= 1'b1;
        print_data_o  <= wdata_i[7:0];       // low byte is the character
      end else if (wr_act) begin
        case (ofs_i)
          `SIMMEM_CTRL_STATUS_OFS: begin
            tests_passed_o <= (wdata_i == `SIMMEM_PASS_MAGIC);
            tests_failed_o <= (wdata_i == `SIMMEM_FAIL_MAGIC);  // other values ignored
          end
          `SIMMEM_CTRL_EXIT_OFS: begin
            exit_valid_o <= 1'b1;
            exit_value_o <= wdata_i;         // exit code as written
          end
          `SIMMEM_CTRL_EXIT0_OFS: begin
            exit_valid_o <= 1'b1;            // exit with code zero
          end
          default: ;                         // unused offsets
        endcase
      end
    end
  end

endmodule

//--- verilog/word_ram.sv
`timescale 1ns/1ns
`include "simmem_defines.svh"

module word_ram (
  input  logic                 clk_i,
  input  logic                 en_i,       // access enable
  input  logic                 we_i,       // write, gated per lane by wstrb_i
  input  simmem_pkg::ram_idx_t idx_i,
  input  simmem_pkg::data_t    wdata_i,
  input  simmem_pkg::strb_t    wstrb_i,
  output simmem_pkg::data_t    rdata_o     // valid one cycle after en_i
);

  localparam int unsigned DEPTH = 1 << `SIMMEM_RAM_IDX_W;

  simmem_pkg::data_t mem [DEPTH];          // contents undefined until written

  // ---------------------------------------------------------------------------
  // byte lane writes, read returns the old word
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      for (int b = 0; b < `SIMMEM_STRB_W; b++) begin
        if (we_i && wstrb_i[b]) begin
          mem[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];  // only strobed lanes
        end
      end
      rdata_o <= mem[idx_i];               // read before write
    end
  end

endmodule

//--- verilog/axil_slave_port.sv
`timescale 1ns/1ns
`include "simmem_defines.svh"

module axil_slave_port (
  input  logic               clk_i,
  input  logic               arst_n_i,
  // axi4-lite slave side
  input  simmem_pkg::addr_t  s_awaddr_i,
  input  logic               s_awvalid_i,
  output logic               s_awready_o,
  input  simmem_pkg::data_t  s_wdata_i,
  input  simmem_pkg::strb_t  s_wstrb_i,
  input  logic               s_wvalid_i,
  output logic               s_wready_o,
  output simmem_pkg::resp_t  s_bresp_o,
  output logic               s_bvalid_o,
  input  logic               s_bready_i,
  input  simmem_pkg::addr_t  s_araddr_i,
  input  logic               s_arvalid_i,
  output logic               s_arready_o,
  output simmem_pkg::data_t  s_rdata_o,
  output simmem_pkg::resp_t  s_rresp_o,
  output logic               s_rvalid_o,
  input  logic               s_rready_i,
  // ram side
  output logic                 ram_en_o,
  output logic                 ram_we_o,
  output simmem_pkg::ram_idx_t ram_idx_o,
  input  simmem_pkg::data_t    ram_rdata_i,
  // host control side
  output logic               ctrl_wr_o,
  output logic               ctrl_print_o,
  output logic [11:0]        ctrl_ofs_o,
  output simmem_pkg::data_t  wdata_o,
  output simmem_pkg::strb_t  wstrb_o
);

  typedef enum logic [1:0] {
    ST_IDLE,                                  // waiting for a request
    ST_WRESP,                                 // b channel pending
    ST_RRESP                                  // r channel pending
  } state_e;

  state_e            state_q;
  logic              wr_hs;                   // aw+w accepted this cycle
  logic              rd_hs;                   // ar accepted this cycle
  simmem_pkg::addr_t acc_addr;                // address of the access in flight
  logic [1:0]        region;                  // decoded target
  logic [1:0]        region_q;                // target of the pending response
  simmem_pkg::resp_t resp_q;                  // code of the pending response

  // ---------------------------------------------------------------------------
  // handshake, write has priority
  // ---------------------------------------------------------------------------
  assign wr_hs = (state_q == ST_IDLE) && s_awvalid_i && s_wvalid_i;
  assign rd_hs = (state_q == ST_IDLE) && !(s_awvalid_i && s_wvalid_i) && s_arvalid_i;

  assign s_awready_o = wr_hs;                 // aw and w taken together
  assign s_wready_o  = wr_hs;
  assign s_arready_o = rd_hs;

  // ---------------------------------------------------------------------------
  // region decode and target strobes
  // ---------------------------------------------------------------------------
  assign acc_addr = wr_hs ? s_awaddr_i : s_araddr_i;
  assign region   = acc_addr[`SIMMEM_REGION_LSB +: 2];

  assign ram_en_o  = (wr_hs || rd_hs) && (region == `SIMMEM_REGION_RAM);
  assign ram_we_o  = wr_hs && (region == `SIMMEM_REGION_RAM);
  assign ram_idx_o = acc_addr[`SIMMEM_RAM_IDX_W+1:2];  // word aligned

  // print and ctrl share the host block, flagged by ctrl_print_o
  assign ctrl_wr_o    = wr_hs && ((region == `SIMMEM_REGION_CTRL) ||
                                  (region == `SIMMEM_REGION_PRINT));
  assign ctrl_print_o = (region == `SIMMEM_REGION_PRINT);
  assign ctrl_ofs_o   = acc_addr[11:0];

  assign wdata_o = s_wdata_i;                 // lanes are checked by the targets
  assign wstrb_o = s_wstrb_i;

  // ---------------------------------------------------------------------------
  // fsm and response registers
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (wr_hs) begin
            state_q <= ST_WRESP;
          end else if (rd_hs) begin
            state_q <= ST_RRESP;
          end
        end
        ST_WRESP: if (s_bready_i) state_q <= ST_IDLE;  // b taken
        ST_RRESP: if (s_rready_i) state_q <= ST_IDLE;  // r taken
        default:  state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_hs || rd_hs) begin
      region_q <= region;
      resp_q   <= (region == 2'd3) ? `SIMMEM_RESP_DECERR : `SIMMEM_RESP_OKAY;  // unmapped
    end
  end

  assign s_bvalid_o = (state_q == ST_WRESP);
  assign s_bresp_o  = resp_q;
  assign s_rvalid_o = (state_q == ST_RRESP);
  assign s_rresp_o  = resp_q;

  // ram output holds while r is stalled, other regions read as zero
  assign s_rdata_o = (region_q == `SIMMEM_REGION_RAM) ? ram_rdata_i : '0;

endmodule

//--- verilog/simmem_pkg.sv
`include "simmem_defines.svh"

package simmem_pkg;

  // ---------------------------------------------------------------------------
  // shared vector types
  // ---------------------------------------------------------------------------
  typedef logic [`SIMMEM_ADDR_W-1:0] addr_t;        // byte address

  typedef logic [`SIMMEM_DATA_W-1:0] data_t;        // one bus word

  typedef logic [`SIMMEM_STRB_W-1:0] strb_t;        // one bit per byte lane

  typedef logic [1:0] resp_t;                       // okay / decerr

  typedef logic [`SIMMEM_RAM_IDX_W-1:0] ram_idx_t;  // word index into the ram

endpackage

//--- verilog/simmem_defines.svh
`ifndef SIMMEM_DEFINES_SVH
`define SIMMEM_DEFINES_SVH

// bus widths
`define SIMMEM_ADDR_W      32
`define SIMMEM_DATA_W      32
`define SIMMEM_STRB_W      4
`define SIMMEM_RAM_IDX_W   10             // 1024 words

// ---------------------------------------------------------------------------
// address map, region select on addr[29:28]
// ---------------------------------------------------------------------------
`define SIMMEM_REGION_LSB  28
`define SIMMEM_REGION_RAM  2'd0           // word ram
`define SIMMEM_REGION_PRINT 2'd1          // character output
`define SIMMEM_REGION_CTRL 2'd2           // exit and status block

// offsets inside the ctrl region
`define SIMMEM_CTRL_STATUS_OFS 12'h000
`define SIMMEM_CTRL_EXIT_OFS   12'h004
`define SIMMEM_CTRL_EXIT0_OFS  12'h010

// magic status values
`define SIMMEM_PASS_MAGIC  32'd123456789
`define SIMMEM_FAIL_MAGIC  32'd1

// axi response codes
`define SIMMEM_RESP_OKAY   2'd0
`define SIMMEM_RESP_DECERR 2'd3

`endif
